/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= tb_mshr_top
FILELIST ?= compile.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

FAIL_MSG  = FAIL: see errors above
PASS_MSG  = PASS: all tests
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
src/mshr_pkg.sv
src/mshr_ctrl.sv
src/mshr_req_arbiter.sv
src/mshr_entry_array.sv
src/mshr_oh_pick.sv
src/mshr_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_mshr_top.sv

/* src/mshr_ctrl.sv */
`timescale 1ns/10ps

module mshr_ctrl (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic [mshr_pkg::ENTRY_IDX_W:0] i_alloc_cnt,
  input  mshr_pkg::entry_oh_t            i_finish,
  output logic [mshr_pkg::ENTRY_IDX_W:0] o_free_cnt,
  output mshr_pkg::entry_oh_t            o_alloc_ptr_oh,
  output mshr_pkg::entry_oh_t            o_retire_ptr_oh,
  output logic                           o_full,
  output logic                           o_empty
);

  logic [mshr_pkg::ENTRY_IDX_W:0]     r_free_cnt;
  mshr_pkg::entry_oh_t                r_alloc_ptr_oh;
  mshr_pkg::entry_oh_t                r_retire_ptr_oh;
  logic                               w_retire;
  logic [2*mshr_pkg::ENTRY_NUM-1:0]   w_alloc_rot;

  assign w_retire    = |i_finish;
  // Upper half of the doubled vector is the rotated pointer
  assign w_alloc_rot = {r_alloc_ptr_oh, r_alloc_ptr_oh} << i_alloc_cnt;

  // --------------------------------------------------------------------
  // Free counter and ring pointers
  // --------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_free_cnt      <= (mshr_pkg::ENTRY_IDX_W+1)'(mshr_pkg::ENTRY_NUM);
      r_alloc_ptr_oh  <= mshr_pkg::entry_oh_t'(1);
      r_retire_ptr_oh <= mshr_pkg::entry_oh_t'(1);
    end else begin
      r_free_cnt <= r_free_cnt - i_alloc_cnt + (mshr_pkg::ENTRY_IDX_W+1)'(w_retire);
      r_alloc_ptr_oh <= w_alloc_rot[2*mshr_pkg::ENTRY_NUM-1:mshr_pkg::ENTRY_NUM];
      if (w_retire) begin
        // Step one entry in allocation order
        r_retire_ptr_oh <= {r_retire_ptr_oh[mshr_pkg::ENTRY_NUM-2:0],
                            r_retire_ptr_oh[mshr_pkg::ENTRY_NUM-1]};
      end
    end
  end

  assign o_free_cnt      = r_free_cnt;
  assign o_alloc_ptr_oh  = r_alloc_ptr_oh;
  assign o_retire_ptr_oh = r_retire_ptr_oh;
  assign o_full          = (r_free_cnt == '0);
  assign o_empty         = (r_free_cnt == (mshr_pkg::ENTRY_IDX_W+1)'(mshr_pkg::ENTRY_NUM));

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------

  // Entries leave strictly in order, one at a time
  a_one_finish: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(i_finish)
  );

  // Counter must never report more space than the ring holds
  a_free_bound: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_free_cnt <= (mshr_pkg::ENTRY_IDX_W+1)'(mshr_pkg::ENTRY_NUM)
  );

  // Arbiter refuses everything when no entry is free
  a_full_no_alloc: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_full |-> (i_alloc_cnt == '0)
  );

endmodule

/* src/mshr_entry_array.sv */
`timescale 1ns/10ps

module mshr_entry_array (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  mshr_pkg::entry_oh_t  i_alloc_oh,
  input  mshr_pkg::paddr_t     i_alloc_paddr [mshr_pkg::ENTRY_NUM],
  input  mshr_pkg::entry_oh_t  i_l2_sent_oh,
  input  mshr_pkg::l2_resp_t   i_l2_resp,
  input  mshr_pkg::entry_oh_t  i_wr_sel_oh,
  input  mshr_pkg::entry_oh_t  i_retire_ptr_oh,
  output mshr_pkg::entry_oh_t  o_entry_valid,
  output mshr_pkg::paddr_t     o_entry_paddr [mshr_pkg::ENTRY_NUM],
  output mshr_pkg::line_data_t o_entry_data [mshr_pkg::ENTRY_NUM],
  output mshr_pkg::entry_oh_t  o_send_ready,
  output mshr_pkg::entry_oh_t  o_wr_ready,
  output mshr_pkg::entry_oh_t  o_finish,
  output mshr_pkg::resolve_t   o_resolve
);

  typedef enum logic [2:0] {
    ST_FREE,
    ST_ALLOC,    // Waiting for the L2 handshake
    ST_SENT,
    ST_GOT,      // Line stored, waiting for the L1D write
    ST_WRITTEN
  } state_e;

  state_e               r_state [mshr_pkg::ENTRY_NUM];
  mshr_pkg::paddr_t     r_paddr [mshr_pkg::ENTRY_NUM];
  mshr_pkg::line_data_t r_data  [mshr_pkg::ENTRY_NUM];
  mshr_pkg::entry_oh_t  w_valid;
  mshr_pkg::entry_oh_t  w_resp_hit;

  assign w_resp_hit = i_l2_resp.valid ? (mshr_pkg::entry_oh_t'(1) << i_l2_resp.tag) : '0;

  // --------------------------------------------------------------------
  // Per-entry FSM and storage
  // --------------------------------------------------------------------
  for (genvar e = 0; e < mshr_pkg::ENTRY_NUM; e++) begin : g_entry
    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_state[e] <= ST_FREE;
      end else begin
        case (r_state[e])
          ST_FREE:    r_state[e] <= i_alloc_oh[e]   ? ST_ALLOC   : ST_FREE;
          ST_ALLOC:   r_state[e] <= i_l2_sent_oh[e] ? ST_SENT    : ST_ALLOC;
          ST_SENT:    r_state[e] <= w_resp_hit[e]   ? ST_GOT     : ST_SENT;
          ST_GOT:     r_state[e] <= i_wr_sel_oh[e]  ? ST_WRITTEN : ST_GOT;
          ST_WRITTEN: r_state[e] <= o_finish[e]     ? ST_FREE    : ST_WRITTEN;
          default:    r_state[e] <= ST_FREE;
        endcase
      end
    end

    always_ff @(posedge i_clk) begin
      if (i_alloc_oh[e]) begin
        r_paddr[e] <= i_alloc_paddr[e];
      end
      if (w_resp_hit[e]) begin
        r_data[e] <= i_l2_resp.data;  // Readable from the next cycle
      end
    end

    assign w_valid[e]      = (r_state[e] != ST_FREE);
    assign o_send_ready[e] = (r_state[e] == ST_ALLOC);
    assign o_wr_ready[e]   = (r_state[e] == ST_GOT);
    assign o_finish[e]     = (r_state[e] == ST_WRITTEN) & i_retire_ptr_oh[e];
    assign o_entry_paddr[e] = r_paddr[e];
    assign o_entry_data[e]  = r_data[e];

    // Arbiter only hands out free slots
    a_alloc_free: assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      i_alloc_oh[e] |-> (r_state[e] == ST_FREE)
    );

    // L2 returns only tags that were requested and not yet answered
    a_resp_sent: assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      w_resp_hit[e] |-> (r_state[e] == ST_SENT)
    );
  end

  assign o_entry_valid          = w_valid;
  assign o_resolve.valid        = i_l2_resp.valid;  // Same cycle as the response
  assign o_resolve.resolve_oh   = w_resp_hit;
  assign o_resolve.entry_valid  = w_valid;

endmodule

/* src/mshr_oh_pick.sv */
`timescale 1ns/10ps

module mshr_oh_pick #(
  parameter type T = mshr_pkg::paddr_t
) (
  input  mshr_pkg::entry_oh_t i_valid,
  input  mshr_pkg::entry_oh_t i_ptr_oh,
  input  T                    i_data [mshr_pkg::ENTRY_NUM],
  output logic                o_valid,
  output mshr_pkg::entry_oh_t o_sel_oh,
  output T                    o_data
);

  mshr_pkg::entry_oh_t w_upper;      // Candidates at or above the pointer
  mshr_pkg::entry_oh_t w_upper_lsb;
  mshr_pkg::entry_oh_t w_all_lsb;    // Wrap-around choice
  logic [$bits(T)-1:0] w_data_or;

  assign w_upper     = i_valid & ~(i_ptr_oh - 1'b1);
  assign w_upper_lsb = w_upper & (~w_upper + 1'b1);
  assign w_all_lsb   = i_valid & (~i_valid + 1'b1);

  assign o_sel_oh = (|w_upper) ? w_upper_lsb : w_all_lsb;
  assign o_valid  = |i_valid;

  // One-hot OR mux
  always_comb begin
    w_data_or = '0;
    for (int e = 0; e < mshr_pkg::ENTRY_NUM; e++) begin
      w_data_or = w_data_or | (i_data[e] & {$bits(T){o_sel_oh[e]}});
    end
  end

  assign o_data = T'(w_data_or);

endmodule

/* src/mshr_pkg.sv */
package mshr_pkg;

  // ---------------------------------------------------------------------
  // Sizes
  // ---------------------------------------------------------------------
  localparam int REQ_PORT_NUM = 2;                     // Load pipes
  localparam int ENTRY_NUM    = 4;
  localparam int ENTRY_IDX_W  = $clog2(ENTRY_NUM);
  localparam int PADDR_W      = 32;
  localparam int LINE_BYTES   = 16;
  localparam int LINE_OFS_W   = $clog2(LINE_BYTES);
  localparam int LINE_DATA_W  = LINE_BYTES * 8;

  typedef logic [PADDR_W-1:0]     paddr_t;
  typedef logic [LINE_DATA_W-1:0] line_data_t;
  typedef logic [ENTRY_NUM-1:0]   entry_oh_t;              // One bit per entry

  // ---------------------------------------------------------------------
  // Port payloads
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic   valid;
    paddr_t paddr;
  } miss_req_t;

  typedef struct packed {
    logic      allocated;  // Entry owns this line now
    logic      full;       // Refused, retry later
    entry_oh_t entry_oh;
  } miss_resp_t;

  typedef struct packed {
    logic                   valid;
    paddr_t                 addr;   // Line address, offset cleared
    logic [ENTRY_IDX_W-1:0] tag;
  } l2_req_t;

  typedef struct packed {
    logic                   valid;
    logic [ENTRY_IDX_W-1:0] tag;
    line_data_t             data;
  } l2_resp_t;

  typedef struct packed {
    logic       valid;
    paddr_t     paddr;
    line_data_t data;
  } l1d_wr_t;

  typedef struct packed {
    logic      valid;
    entry_oh_t resolve_oh;
    entry_oh_t entry_valid;
  } resolve_t;

endpackage

/* src/mshr_req_arbiter.sv */
`timescale 1ns/10ps

module mshr_req_arbiter (
  input  mshr_pkg::miss_req_t            i_miss_req [mshr_pkg::REQ_PORT_NUM],
  input  mshr_pkg::entry_oh_t            i_entry_valid,
  input  mshr_pkg::entry_oh_t            i_entry_finish,
  input  mshr_pkg::paddr_t               i_entry_paddr [mshr_pkg::ENTRY_NUM],
  input  mshr_pkg::entry_oh_t            i_alloc_ptr_oh,
  input  logic [mshr_pkg::ENTRY_IDX_W:0] i_free_cnt,
  output mshr_pkg::miss_resp_t           o_miss_resp [mshr_pkg::REQ_PORT_NUM],
  output mshr_pkg::entry_oh_t            o_alloc_oh,
  output mshr_pkg::paddr_t               o_alloc_paddr [mshr_pkg::ENTRY_NUM],
  output logic [mshr_pkg::ENTRY_IDX_W:0] o_alloc_cnt
);

  function automatic logic same_line(mshr_pkg::paddr_t a, mshr_pkg::paddr_t b);
    return a[mshr_pkg::PADDR_W-1:mshr_pkg::LINE_OFS_W] ==
           b[mshr_pkg::PADDR_W-1:mshr_pkg::LINE_OFS_W];
  endfunction

  function automatic mshr_pkg::paddr_t line_addr(mshr_pkg::paddr_t a);
    return {a[mshr_pkg::PADDR_W-1:mshr_pkg::LINE_OFS_W], {mshr_pkg::LINE_OFS_W{1'b0}}};
  endfunction

  // --------------------------------------------------------------------
  // Conflict check, ranking and placement, in port order
  // --------------------------------------------------------------------
  always_comb begin
    logic [2*mshr_pkg::ENTRY_NUM-1:0] rot;
    logic [mshr_pkg::ENTRY_IDX_W:0]   rank;
    mshr_pkg::entry_oh_t              hit_entry;
    mshr_pkg::entry_oh_t              port_oh;
    mshr_pkg::entry_oh_t              target_oh;
    logic                             port_hit;
    logic                             conflict;
    logic                             no_conflict;
    logic                             granted;

    rank        = '0;
    o_alloc_oh  = '0;
    o_alloc_cnt = '0;
    for (int e = 0; e < mshr_pkg::ENTRY_NUM; e++) begin
      o_alloc_paddr[e] = '0;
    end

    for (int p = 0; p < mshr_pkg::REQ_PORT_NUM; p++) begin
      // Outstanding misses, skipping the one that leaves this cycle
      for (int e = 0; e < mshr_pkg::ENTRY_NUM; e++) begin
        hit_entry[e] = i_miss_req[p].valid & i_entry_valid[e] & ~i_entry_finish[e] &
                       same_line(i_miss_req[p].paddr, i_entry_paddr[e]);
      end

      // Lower ports that already got an entry for this line
      port_hit = 1'b0;
      port_oh  = '0;
      for (int q = 0; q < p; q++) begin
        if (!port_hit && i_miss_req[p].valid && o_miss_resp[q].allocated &&
            same_line(i_miss_req[p].paddr, i_miss_req[q].paddr)) begin
          port_hit = 1'b1;
          port_oh  = o_miss_resp[q].entry_oh;
        end
      end

      conflict    = (|hit_entry) | port_hit;
      no_conflict = i_miss_req[p].valid & ~conflict;
      if (no_conflict) begin
        rank = rank + 1'b1;  // 1-based position among new lines
      end
      granted   = no_conflict & (rank <= i_free_cnt);
      rot       = {i_alloc_ptr_oh, i_alloc_ptr_oh} << (rank - 1'b1);
      target_oh = granted ? rot[2*mshr_pkg::ENTRY_NUM-1:mshr_pkg::ENTRY_NUM] : '0;

      o_miss_resp[p].allocated = granted | conflict;
      o_miss_resp[p].full      = no_conflict & ~granted;
      if (granted) begin
        o_miss_resp[p].entry_oh = target_oh;
      end else if (|hit_entry) begin
        o_miss_resp[p].entry_oh = hit_entry;
      end else begin
        o_miss_resp[p].entry_oh = port_oh;  // Zero when refused or idle
      end

      if (granted) begin
        o_alloc_oh  = o_alloc_oh | target_oh;
        o_alloc_cnt = o_alloc_cnt + 1'b1;
        for (int e = 0; e < mshr_pkg::ENTRY_NUM; e++) begin
          if (target_oh[e]) begin
            o_alloc_paddr[e] = line_addr(i_miss_req[p].paddr);
          end
        end
      end
    end
  end

endmodule

/* src/mshr_top.sv */
`timescale 1ns/10ps

module mshr_top (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  mshr_pkg::miss_req_t  i_miss_req [mshr_pkg::REQ_PORT_NUM],
  output mshr_pkg::miss_resp_t o_miss_resp [mshr_pkg::REQ_PORT_NUM],
  output mshr_pkg::l2_req_t    o_l2_req,
  input  logic                 i_l2_req_ready,
  input  mshr_pkg::l2_resp_t   i_l2_resp,
  output mshr_pkg::l1d_wr_t    o_l1d_wr,
  output mshr_pkg::resolve_t   o_resolve,
  output logic                 o_full,
  output logic                 o_empty
);

  logic [mshr_pkg::ENTRY_IDX_W:0]   w_free_cnt;
  logic [mshr_pkg::ENTRY_IDX_W:0]   w_alloc_cnt;
  logic [mshr_pkg::ENTRY_IDX_W-1:0] w_send_tag;
  mshr_pkg::entry_oh_t              w_alloc_ptr_oh;
  mshr_pkg::entry_oh_t              w_retire_ptr_oh;
  mshr_pkg::entry_oh_t              w_alloc_oh;
  mshr_pkg::paddr_t                 w_alloc_paddr [mshr_pkg::ENTRY_NUM];
  mshr_pkg::entry_oh_t              w_entry_valid;
  mshr_pkg::entry_oh_t              w_finish;
  mshr_pkg::paddr_t                 w_entry_paddr [mshr_pkg::ENTRY_NUM];
  mshr_pkg::line_data_t             w_entry_data  [mshr_pkg::ENTRY_NUM];
  mshr_pkg::entry_oh_t              w_send_ready;
  mshr_pkg::entry_oh_t              w_wr_ready;
  mshr_pkg::entry_oh_t              w_l2_sent_oh;

  // Send pick
  logic                             w_send_valid;
  mshr_pkg::entry_oh_t              w_send_sel_oh;
  mshr_pkg::paddr_t                 w_send_paddr;

  // Fill write pick
  logic                             w_wr_valid;
  mshr_pkg::entry_oh_t              w_wr_sel_oh;
  mshr_pkg::l1d_wr_t                w_wr_cand [mshr_pkg::ENTRY_NUM];
  mshr_pkg::l1d_wr_t                w_wr_pick;

  mshr_ctrl u_ctrl (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_alloc_cnt     (w_alloc_cnt),
    .i_finish        (w_finish),
    .o_free_cnt      (w_free_cnt),
    .o_alloc_ptr_oh  (w_alloc_ptr_oh),
    .o_retire_ptr_oh (w_retire_ptr_oh),
    .o_full          (o_full),
    .o_empty         (o_empty)
  );

  mshr_req_arbiter u_arbiter (
    .i_miss_req     (i_miss_req),
    .i_entry_valid  (w_entry_valid),
    .i_entry_finish (w_finish),
    .i_entry_paddr  (w_entry_paddr),
    .i_alloc_ptr_oh (w_alloc_ptr_oh),
    .i_free_cnt     (w_free_cnt),
    .o_miss_resp    (o_miss_resp),
    .o_alloc_oh     (w_alloc_oh),
    .o_alloc_paddr  (w_alloc_paddr),
    .o_alloc_cnt    (w_alloc_cnt)
  );

  mshr_entry_array u_entries (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_alloc_oh      (w_alloc_oh),
    .i_alloc_paddr   (w_alloc_paddr),
    .i_l2_sent_oh    (w_l2_sent_oh),
    .i_l2_resp       (i_l2_resp),
    .i_wr_sel_oh     (w_wr_sel_oh),
    .i_retire_ptr_oh (w_retire_ptr_oh),
    .o_entry_valid   (w_entry_valid),
    .o_entry_paddr   (w_entry_paddr),
    .o_entry_data    (w_entry_data),
    .o_send_ready    (w_send_ready),
    .o_wr_ready      (w_wr_ready),
    .o_finish        (w_finish),
    .o_resolve       (o_resolve)
  );

  // --------------------------------------------------------------------
  // L2 read request
  // --------------------------------------------------------------------
  mshr_oh_pick #(.T(mshr_pkg::paddr_t)) u_send_pick (
    .i_valid  (w_send_ready),
    .i_ptr_oh (w_retire_ptr_oh),
    .i_data   (w_entry_paddr),
    .o_valid  (w_send_valid),
    .o_sel_oh (w_send_sel_oh),
    .o_data   (w_send_paddr)
  );

  always_comb begin
    w_send_tag = '0;
    for (int e = 0; e < mshr_pkg::ENTRY_NUM; e++) begin
      if (w_send_sel_oh[e]) begin
        w_send_tag = (mshr_pkg::ENTRY_IDX_W)'(e);
      end
    end
  end

  assign w_l2_sent_oh = w_send_sel_oh & {mshr_pkg::ENTRY_NUM{w_send_valid & i_l2_req_ready}};
  assign o_l2_req     = '{valid: w_send_valid, addr: w_send_paddr, tag: w_send_tag};

  // --------------------------------------------------------------------
  // L1D fill write
  // --------------------------------------------------------------------
  for (genvar e = 0; e < mshr_pkg::ENTRY_NUM; e++) begin : g_wr_cand
    assign w_wr_cand[e] = '{valid: w_wr_ready[e], paddr: w_entry_paddr[e],
                            data: w_entry_data[e]};
  end

  mshr_oh_pick #(.T(mshr_pkg::l1d_wr_t)) u_wr_pick (
    .i_valid  (w_wr_ready),
    .i_ptr_oh (w_retire_ptr_oh),  // Oldest first
    .i_data   (w_wr_cand),
    .o_valid  (w_wr_valid),
    .o_sel_oh (w_wr_sel_oh),
    .o_data   (w_wr_pick)
  );

  assign o_l1d_wr = '{valid: w_wr_valid, paddr: w_wr_pick.paddr, data: w_wr_pick.data};

endmodule

/* testbench/tb_checker.sv */
`timescale 1ns/10ps

module tb_checker (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  mshr_pkg::miss_req_t  i_miss_req  [mshr_pkg::REQ_PORT_NUM],
  input  mshr_pkg::miss_resp_t i_miss_resp [mshr_pkg::REQ_PORT_NUM],
  input  mshr_pkg::miss_resp_t i_exp_resp  [mshr_pkg::REQ_PORT_NUM],
  input  mshr_pkg::l2_req_t    i_l2_req,
  input  logic                 i_l2_req_ready,
  input  mshr_pkg::l2_resp_t   i_l2_resp,
  input  mshr_pkg::l1d_wr_t    i_l1d_wr,
  input  mshr_pkg::resolve_t   i_resolve,
  input  logic                 i_full,
  input  logic                 i_empty,
  output int                   o_err_cnt,
  output int                   o_check_cnt
);

  typedef enum logic [2:0] {
    M_FREE,
    M_ALLOC,
    M_SENT,
    M_GOT,
    M_WRITTEN
  } mstate_e;

  mstate_e              m_state [mshr_pkg::ENTRY_NUM];
  mstate_e              m_pre   [mshr_pkg::ENTRY_NUM];  // State during the sampled cycle
  mshr_pkg::paddr_t     m_line  [mshr_pkg::ENTRY_NUM];
  mshr_pkg::line_data_t m_data  [mshr_pkg::ENTRY_NUM];
  int                   m_order [$];                    // Live entries, oldest first
  int                   err_cnt = 0;
  int                   check_cnt = 0;

  assign o_err_cnt   = err_cnt;
  assign o_check_cnt = check_cnt;

  function automatic mshr_pkg::paddr_t line_of(mshr_pkg::paddr_t a);
    return a & ~mshr_pkg::paddr_t'(mshr_pkg::LINE_BYTES - 1);
  endfunction

  function automatic int oh_to_idx(mshr_pkg::entry_oh_t oh);
    int idx;
    idx = -1;
    if ($onehot(oh)) begin
      for (int e = 0; e < mshr_pkg::ENTRY_NUM; e++) begin
        if (oh[e]) idx = e;
      end
    end
    return idx;
  endfunction

  // Oldest live entry in a given state, -1 if none
  function automatic int oldest_in(mstate_e st);
    int idx;
    idx = -1;
    for (int i = m_order.size() - 1; i >= 0; i--) begin
      if (m_pre[m_order[i]] == st) idx = m_order[i];
    end
    return idx;
  endfunction

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  // ------------------------------------------------------------------
  // Reference model, one step per rising edge
  // ------------------------------------------------------------------
  always @(posedge i_clk) begin : model_step
    int                  occ;
    int                  idx;
    mshr_pkg::entry_oh_t valid_mask;
    mshr_pkg::entry_oh_t exp_oh;
    mshr_pkg::paddr_t    req_line;

    if (!i_reset_n) begin
      for (int e = 0; e < mshr_pkg::ENTRY_NUM; e++) m_state[e] = M_FREE;
      m_order.delete();
    end else begin
      occ        = 0;
      valid_mask = '0;
      for (int e = 0; e < mshr_pkg::ENTRY_NUM; e++) begin
        m_pre[e] = m_state[e];
        if (m_state[e] != M_FREE) begin
          occ++;
          valid_mask[e] = 1'b1;
        end
      end
      check_val("o_full", 128'(i_full), 128'(occ == mshr_pkg::ENTRY_NUM));
      check_val("o_empty", 128'(i_empty), 128'(occ == 0));

      // Head leaves once its line is written
      if (m_order.size() > 0 && m_pre[m_order[0]] == M_WRITTEN) begin
        idx = m_order.pop_front();
        m_state[idx] = M_FREE;
      end

      idx = oldest_in(M_GOT);
      check_val("o_l1d_wr.valid", 128'(i_l1d_wr.valid), 128'(idx >= 0));
      if (idx >= 0 && i_l1d_wr.valid) begin
        check_val("o_l1d_wr.paddr", 128'(i_l1d_wr.paddr), 128'(m_line[idx]));
        check_val("o_l1d_wr.data", i_l1d_wr.data, m_data[idx]);
        m_state[idx] = M_WRITTEN;
      end

      check_val("o_resolve.valid", 128'(i_resolve.valid), 128'(i_l2_resp.valid));
      if (i_l2_resp.valid) begin
        exp_oh                = '0;
        exp_oh[i_l2_resp.tag] = 1'b1;
        check_val("o_resolve.resolve_oh", 128'(i_resolve.resolve_oh), 128'(exp_oh));
        check_val("o_resolve.entry_valid", 128'(i_resolve.entry_valid), 128'(valid_mask));
        if (m_pre[i_l2_resp.tag] != M_SENT) begin
          report_error($sformatf("L2 response for entry %0d, which has no read in flight",
                                 i_l2_resp.tag));
        end else begin
          m_state[i_l2_resp.tag] = M_GOT;
          m_data[i_l2_resp.tag]  = i_l2_resp.data;
        end
      end

      idx = oldest_in(M_ALLOC);
      check_val("o_l2_req.valid", 128'(i_l2_req.valid), 128'(idx >= 0));
      if (idx >= 0 && i_l2_req.valid) begin
        check_val("o_l2_req.addr", 128'(i_l2_req.addr), 128'(m_line[idx]));
        check_val("o_l2_req.tag", 128'(i_l2_req.tag), 128'(idx));
        if (i_l2_req_ready) m_state[idx] = M_SENT;
      end

      for (int p = 0; p < mshr_pkg::REQ_PORT_NUM; p++) begin
        check_val($sformatf("o_miss_resp[%0d]", p), 128'(i_miss_resp[p]),
                  128'(i_exp_resp[p]));
        if (i_miss_req[p].valid && i_miss_resp[p].allocated) begin
          req_line = line_of(i_miss_req[p].paddr);
          idx      = oh_to_idx(i_miss_resp[p].entry_oh);
          if (idx < 0) begin
            report_error($sformatf("port %0d allocated without a one-hot entry", p));
          end else if (m_pre[idx] == M_FREE && m_state[idx] == M_FREE) begin
            m_state[idx] = M_ALLOC;  // New line
            m_line[idx]  = req_line;
            m_order.push_back(idx);
          end else begin
            check_val("line of the matched entry", 128'(m_line[idx]), 128'(req_line));
          end
        end
      end
    end
  end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);

  // 20 ns period
  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (5) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;  // Released away from the active edge
  end

endmodule

/* testbench/tb_mshr_top.sv */
`timescale 1ns/10ps

module tb_mshr_top;

  localparam int NUM_ROWS       = 14;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40;

  typedef struct packed {
    logic [7:0]           cycles;      // Times the row is repeated
    logic                 req0_valid;
    mshr_pkg::paddr_t     req0_addr;
    logic                 req1_valid;
    mshr_pkg::paddr_t     req1_addr;
    logic                 l2_ready;
    logic                 l2_resp_en;  // L2 model may answer
    mshr_pkg::miss_resp_t exp0;
    mshr_pkg::miss_resp_t exp1;
  } row_t;

  logic                 clk;
  logic                 reset_n;
  mshr_pkg::miss_req_t  miss_req  [mshr_pkg::REQ_PORT_NUM];
  mshr_pkg::miss_resp_t miss_resp [mshr_pkg::REQ_PORT_NUM];
  mshr_pkg::miss_resp_t exp_resp  [mshr_pkg::REQ_PORT_NUM];
  mshr_pkg::l2_req_t    l2_req;
  logic                 l2_req_ready;
  mshr_pkg::l2_resp_t   l2_resp;
  mshr_pkg::l1d_wr_t    l1d_wr;
  mshr_pkg::resolve_t   resolve;
  logic                 full;
  logic                 empty;
  int                   err_cnt;
  int                   check_cnt;
  int                   cycle_cnt = 0;
  row_t                 rows [NUM_ROWS];

  // Reads in flight at the L2 model
  logic [mshr_pkg::ENTRY_IDX_W-1:0] pend_tag  [$];
  mshr_pkg::paddr_t                 pend_addr [$];
  int                               pend_due  [$];

  tb_clock_gen u_clock_gen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  mshr_top mshr_top_i (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_miss_req     (miss_req),
    .o_miss_resp    (miss_resp),
    .o_l2_req       (l2_req),
    .i_l2_req_ready (l2_req_ready),
    .i_l2_resp      (l2_resp),
    .o_l1d_wr       (l1d_wr),
    .o_resolve      (resolve),
    .o_full         (full),
    .o_empty        (empty)
  );

  tb_checker u_checker (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_miss_req     (miss_req),
    .i_miss_resp    (miss_resp),
    .i_exp_resp     (exp_resp),
    .i_l2_req       (l2_req),
    .i_l2_req_ready (l2_req_ready),
    .i_l2_resp      (l2_resp),
    .i_l1d_wr       (l1d_wr),
    .i_resolve      (resolve),
    .i_full         (full),
    .i_empty        (empty),
    .o_err_cnt      (err_cnt),
    .o_check_cnt    (check_cnt)
  );

  function automatic mshr_pkg::miss_resp_t resp_new(mshr_pkg::entry_oh_t oh);
    return '{allocated: 1'b1, full: 1'b0, entry_oh: oh};
  endfunction

  function automatic mshr_pkg::miss_resp_t resp_full();
    return '{allocated: 1'b0, full: 1'b1, entry_oh: '0};
  endfunction

  function automatic mshr_pkg::miss_resp_t resp_none();
    return '0;
  endfunction

  // Memory contents, a mix of every address bit
  function automatic mshr_pkg::line_data_t line_data(mshr_pkg::paddr_t a);
    return {a ^ 32'hA5A5_5A5A, ~a, a + 32'h0101_0101, {a[15:0], a[31:16]}};
  endfunction

  // ------------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------------
  task automatic load_table();
    // Single miss, then a same-line pair
    rows[0]  = '{8'd1, 1'b1, 32'h0000_1004, 1'b0, 32'h0, 1'b1, 1'b0,
                 resp_new(4'b0001), resp_none()};
    rows[1]  = '{8'd1, 1'b1, 32'h0000_2008, 1'b1, 32'h0000_200C, 1'b1, 1'b0,
                 resp_new(4'b0010), resp_new(4'b0010)};
    // L2 stalls, hits on pending lines
    rows[2]  = '{8'd1, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, resp_none(), resp_none()};
    rows[3]  = '{8'd1, 1'b1, 32'h0000_1000, 1'b1, 32'h0000_2004, 1'b0, 1'b0,
                 resp_new(4'b0001), resp_new(4'b0010)};
    rows[4]  = '{8'd2, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, resp_none(), resp_none()};
    rows[5]  = '{8'd16, 1'b0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b1, resp_none(), resp_none()};
    // Fill all four entries, then get refused
    rows[6]  = '{8'd1, 1'b1, 32'h0000_3001, 1'b1, 32'h0000_4002, 1'b0, 1'b0,
                 resp_new(4'b0100), resp_new(4'b1000)};
    rows[7]  = '{8'd1, 1'b1, 32'h0000_5000, 1'b1, 32'h0000_6000, 1'b0, 1'b0,
                 resp_new(4'b0001), resp_new(4'b0010)};
    rows[8]  = '{8'd1, 1'b1, 32'h0000_7000, 1'b1, 32'h0000_3008, 1'b0, 1'b0,
                 resp_full(), resp_new(4'b0100)};
    rows[9]  = '{8'd1, 1'b1, 32'h0000_7000, 1'b1, 32'h0000_7004, 1'b1, 1'b0,
                 resp_full(), resp_full()};
    rows[10] = '{8'd6, 1'b0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0, resp_none(), resp_none()};
    rows[11] = '{8'd20, 1'b0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b1, resp_none(), resp_none()};
    // Old line comes back as a fresh miss
    rows[12] = '{8'd1, 1'b1, 32'h0000_1000, 1'b0, 32'h0, 1'b1, 1'b1,
                 resp_new(4'b0100), resp_none()};
    rows[13] = '{8'd12, 1'b0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b1, resp_none(), resp_none()};
  endtask

  // Answers the first read whose delay has run out
  task automatic drive_l2_resp(input logic enable);
    int pick;
    pick    = -1;
    l2_resp = '0;
    if (enable) begin
      for (int i = pend_tag.size() - 1; i >= 0; i--) begin
        if (pend_due[i] <= cycle_cnt) pick = i;
      end
    end
    if (pick >= 0) begin
      l2_resp = '{valid: 1'b1, tag: pend_tag[pick], data: line_data(pend_addr[pick])};
      pend_tag.delete(pick);
      pend_addr.delete(pick);
      pend_due.delete(pick);
    end
  endtask

  task automatic apply_row(input row_t r);
    miss_req[0]  = '{valid: r.req0_valid, paddr: r.req0_addr};
    miss_req[1]  = '{valid: r.req1_valid, paddr: r.req1_addr};
    exp_resp[0]  = r.exp0;
    exp_resp[1]  = r.exp1;
    l2_req_ready = r.l2_ready;
    drive_l2_resp(r.l2_resp_en);
  endtask

  // Cycle count, accepted L2 reads and the run limit
  initial begin : l2_accept
    void'($urandom(31));  // Fixed seed for the L2 delays
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt = cycle_cnt + 1;
      if (reset_n && l2_req.valid && l2_req_ready) begin
        pend_tag.push_back(l2_req.tag);
        pend_addr.push_back(l2_req.addr);
        pend_due.push_back(cycle_cnt + 1 + int'($urandom % 4));
      end
    end
    $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : stimulus
    for (int p = 0; p < mshr_pkg::REQ_PORT_NUM; p++) begin
      miss_req[p] = '0;
      exp_resp[p] = '0;
    end
    l2_req_ready = 1'b0;
    l2_resp      = '0;
    load_table();

    @(posedge reset_n);
    for (int i = 0; i < NUM_ROWS; i++) begin
      for (int c = 0; c < int'(rows[i].cycles); c++) begin
        @(negedge clk);
        apply_row(rows[i]);
      end
    end

    // Let the MSHR drain completely
    while (!(empty && pend_tag.size() == 0)) begin
      @(negedge clk);
      apply_row(row_t'{8'd1, 1'b0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b1,
                       resp_none(), resp_none()});
    end
    repeat (2) @(negedge clk);

    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
